/* project.f */
logic/core_pkg.sv
logic/alu_unit.sv
logic/advint_unit.sv
logic/branch_unit.sv
logic/commit.sv
logic/register_file.sv
logic/exec_backend.sv
verification/exec_backend_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module exec_backend_tb \
		-f project.f -Mdir obj_dir -o sim_exec_backend
	out="$$(./obj_dir/sim_exec_backend)"; echo "$$out"; \
		echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* verification/exec_backend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_backend_tb import core_pkg::*; ();

    logic     clk;
    logic     rst_n;
    logic     alu1_issue;
    alu_req_t alu1_req;
    logic     alu2_issue;
    alu_req_t alu2_req;
    logic     adv_issue;
    adv_req_t adv_req;
    logic     br_issue;
    br_req_t  br_req;
    logic     alu1_stall;
    logic     alu2_stall;
    logic     adv_stall;
    logic     br_stall;
    reg_num_t rd_rn;
    xlen_t    rd_data;

    // flipping the sign bit turns a signed compare into an unsigned one
    localparam xlen_t sign_bit = 64'h8000_0000_0000_0000;

    // expected register contents, updated at the moment an operation is issued
    xlen_t model [64];

    logic [31:0] rng_state;
    int          check_errors;
    int          assert_errors;
    int          timeouts;

    // pending results as the issue side sees them, from the stall rule alone
    logic alu1_pend;
    logic alu2_pend;
    logic adv_pend;
    logic br_pend;

    exec_backend #(
        .num_regs (64)
    ) i_exec_backend (
        .clk        (clk),
        .rst_n      (rst_n),
        .alu1_issue (alu1_issue),
        .alu1_req   (alu1_req),
        .alu2_issue (alu2_issue),
        .alu2_req   (alu2_req),
        .adv_issue  (adv_issue),
        .adv_req    (adv_req),
        .br_issue   (br_issue),
        .br_req     (br_req),
        .alu1_stall (alu1_stall),
        .alu2_stall (alu2_stall),
        .adv_stall  (adv_stall),
        .br_stall   (br_stall),
        .rd_rn      (rd_rn),
        .rd_data    (rd_data)
    );

    always #2 clk = ~clk;

    // a result appears after an accepted strobe and leaves on an unstalled edge
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu1_pend <= 1'b0;
            alu2_pend <= 1'b0;
            adv_pend  <= 1'b0;
            br_pend   <= 1'b0;
        end else begin
            if (!alu1_stall) alu1_pend <= alu1_issue;
            if (!alu2_stall) alu2_pend <= alu2_issue;
            if (!adv_stall) adv_pend <= adv_issue;
            if (!br_stall) br_pend <= br_issue;
        end
    end

    // a unit is only ever held back while it still has a result to write
    a_alu1_stall_pending: assert property (
        @(posedge clk) disable iff (!rst_n) alu1_stall |-> alu1_pend
    ) else begin
        assert_errors++;
        $display("alu1_stall is high while alu1 has no pending result");
    end

    a_alu2_stall_pending: assert property (
        @(posedge clk) disable iff (!rst_n) alu2_stall |-> alu2_pend
    ) else begin
        assert_errors++;
        $display("alu2_stall is high while alu2 has no pending result");
    end

    a_adv_stall_pending: assert property (
        @(posedge clk) disable iff (!rst_n) adv_stall |-> adv_pend
    ) else begin
        assert_errors++;
        $display("adv_stall is high while advint has no pending result");
    end

    a_br_stall_pending: assert property (
        @(posedge clk) disable iff (!rst_n) br_stall |-> br_pend
    ) else begin
        assert_errors++;
        $display("br_stall is high while the branch unit has no pending result");
    end

    // xorshift32 step, the state lives in rng_state
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic xlen_t rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi, lo};
    endfunction

    function automatic xlen_t alu_expect(alu_op_t op, xlen_t a, xlen_t b);
        case (op)
            alu_add: return a + b;
            alu_sub: return a + ~b + xlen_t'(1);
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            alu_sll: return a << b[5:0];
            alu_srl: return a >> b[5:0];
            default: return ((a ^ sign_bit) < (b ^ sign_bit)) ? xlen_t'(1) : xlen_t'(0);
        endcase
    endfunction

    function automatic logic branch_taken(br_op_t op, xlen_t a, xlen_t b);
        case (op)
            br_beq:  return a == b;
            br_bne:  return a != b;
            br_blt:  return (a ^ sign_bit) < (b ^ sign_bit);
            default: return a < b;
        endcase
    endfunction

    // these three are called right after a rising edge and only schedule inputs
    task automatic send_alu(input int unit, input alu_op_t op, input xlen_t a,
                            input xlen_t b, input reg_num_t rn);
        alu_req_t req;
        req.op = op;
        req.a  = a;
        req.b  = b;
        req.rn = rn;
        if (unit == 0) begin
            alu1_issue <= 1'b1;
            alu1_req   <= req;
        end else begin
            alu2_issue <= 1'b1;
            alu2_req   <= req;
        end
        model[rn] = alu_expect(op, a, b);
    endtask

    task automatic send_mul(input xlen_t a, input xlen_t b, input reg_num_t rn,
                            input reg_num_t rn2);
        adv_req_t       req;
        logic [127:0] full;
        req.a   = a;
        req.b   = b;
        req.rn  = rn;
        req.rn2 = rn2;
        adv_issue <= 1'b1;
        adv_req   <= req;
        full = {64'd0, a} * {64'd0, b};
        model[rn]  = full[63:0];
        model[rn2] = full[127:64];
    endtask

    task automatic send_branch(input br_op_t op, input xlen_t a, input xlen_t b,
                               input xlen_t pc, input xlen_t target);
        br_req_t req;
        req.op     = op;
        req.a      = a;
        req.b      = b;
        req.pc     = pc;
        req.target = target;
        br_issue <= 1'b1;
        br_req   <= req;
        model[pc_reg] = branch_taken(op, a, b) ? target : pc + xlen_t'(4);
    endtask

    task automatic drop_strobes();
        alu1_issue <= 1'b0;
        alu2_issue <= 1'b0;
        adv_issue  <= 1'b0;
        br_issue   <= 1'b0;
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout: %s did not happen in time", what);
    endtask

    // compares rd_data at a falling edge, rd_rn must already point at rn
    task automatic compare_rd(input int rn, input xlen_t expected);
        assert (rd_data == expected) else begin
            check_errors++;
            $display("FAIL rd_data reg %0d: got %h expected %h", rn, rd_data, expected);
        end
    endtask

    task automatic check_reg(input int rn);
        @(posedge clk);
        rd_rn <= reg_num_t'(rn);
        @(negedge clk);
        compare_rd(rn, model[rn]);
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < 64; i++) begin
            check_reg(i);
        end
    endtask

    // all stalls low means at most one write is left, it lands on the next edge
    task automatic drain();
        int n;
        @(posedge clk);
        drop_strobes();
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while ((alu1_stall || alu2_stall || adv_stall || br_stall) && n < 64);
        if (alu1_stall || alu2_stall || adv_stall || br_stall) begin
            report_timeout("draining the pending results");
        end
        @(posedge clk);
    endtask

    initial begin
        xlen_t       a;
        xlen_t       b;
        xlen_t       pc;
        xlen_t       target;
        logic        taken;
        int          n;
        int          n1;
        int          n2;
        logic [31:0] r;
        logic        free1;
        logic        free2;
        logic        free_adv;
        logic        free_br;

        clk           = 1'b0;
        rst_n         = 1'b0;
        alu1_issue    = 1'b0;
        alu1_req      = '0;
        alu2_issue    = 1'b0;
        alu2_req      = '0;
        adv_issue     = 1'b0;
        adv_req       = '0;
        br_issue      = 1'b0;
        br_req        = '0;
        rd_rn         = '0;
        rng_state     = 32'h1012e989;
        check_errors  = 0;
        assert_errors = 0;
        timeouts      = 0;
        for (int i = 0; i < 64; i++) begin
            model[i] = '0;
        end

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // out of reset nothing is held and the whole file reads zero
        @(negedge clk);
        assert (!alu1_stall && !alu2_stall && !adv_stall && !br_stall) else begin
            check_errors++;
            $display("a stall is high right after reset");
        end
        check_all_regs();

        // every ALU operation alone, alternating units, read two edges later
        for (int k = 0; k < 8; k++) begin
            a = rand_word();
            b = rand_word();
            @(posedge clk);
            send_alu(k % 2, alu_op_t'(k), a, b, reg_num_t'(k + 1));
            rd_rn <= reg_num_t'(k + 1);
            @(posedge clk);
            drop_strobes();
            @(posedge clk);
            @(negedge clk);
            compare_rd(k + 1, model[k + 1]);
        end

        // branch wins first, so both ALUs wait and alu2 waits one cycle more
        a = rand_word();
        @(posedge clk);
        send_branch(br_beq, a, a, rand_word(), rand_word());
        send_alu(0, alu_add, rand_word(), rand_word(), 6'd10);
        send_alu(1, alu_xor, rand_word(), rand_word(), 6'd11);
        @(posedge clk);
        drop_strobes();
        @(negedge clk);
        assert (alu1_stall && alu2_stall && !br_stall) else begin
            check_errors++;
            $display("both ALU stalls did not rise behind the branch write");
        end
        n1 = 1;
        n2 = 1;
        n  = 0;
        while ((alu1_stall || alu2_stall) && n < 16) begin
            @(negedge clk);
            n++;
            if (alu1_stall) n1++;
            if (alu2_stall) n2++;
        end
        if (alu1_stall || alu2_stall) report_timeout("release of the ALU stalls");
        assert (n2 > n1) else begin
            check_errors++;
            $display("alu2 was not held longer than alu1 behind the branch");
        end
        drain();
        check_reg(pc_reg);
        check_reg(10);
        check_reg(11);

        // the hi half keeps the port even though alu1 arrives in between
        @(posedge clk);
        send_mul(rand_word(), rand_word(), 6'd20, 6'd21);
        @(posedge clk);
        adv_issue <= 1'b0;
        send_alu(0, alu_sub, rand_word(), rand_word(), 6'd12);
        @(negedge clk);
        assert (adv_stall) else begin
            check_errors++;
            $display("adv_stall is low during the write of the low half");
        end
        @(posedge clk);
        alu1_issue <= 1'b0;
        @(negedge clk);
        n = 1;
        while (adv_stall && n < 16) begin
            n++;
            @(negedge clk);
        end
        if (adv_stall) report_timeout("release of adv_stall");
        assert (n == 1 && alu1_stall) else begin
            check_errors++;
            $display("the high half did not follow the low half directly");
        end
        drain();
        check_reg(20);
        check_reg(21);
        check_reg(12);

        // each compare once true and once false
        for (int k = 0; k < 8; k++) begin
            a      = rand_word();
            pc     = rand_word() & ~xlen_t'(3);
            target = rand_word() & ~xlen_t'(3);
            taken  = (k % 2 == 0);
            case (k)
                0, 3:    b = a;
                1, 2:    b = a ^ xlen_t'(1);
                4, 7: begin
                    // minus five against three
                    a = 64'hffff_ffff_ffff_fffb;
                    b = 64'd3;
                end
                default: begin
                    a = 64'd3;
                    b = 64'hffff_ffff_ffff_fffb;
                end
            endcase
            @(posedge clk);
            send_branch(br_op_t'(k / 2), a, b, pc, target);
            rd_rn <= pc_reg;
            @(posedge clk);
            drop_strobes();
            @(posedge clk);
            @(negedge clk);
            compare_rd(pc_reg, taken ? target : pc + xlen_t'(4));
        end

        // random traffic, each unit has its own destination range
        // so the final contents do not depend on the write order
        for (int c = 0; c < 600; c++) begin
            @(negedge clk);
            // a unit neither stalled nor strobed now has no result next cycle
            free1    = !alu1_stall && !alu1_issue;
            free2    = !alu2_stall && !alu2_issue;
            free_adv = !adv_stall && !adv_issue;
            free_br  = !br_stall && !br_issue;
            @(posedge clk);
            drop_strobes();
            r = next_rand();
            rd_rn <= reg_num_t'(r[29:24]);
            if (free1 && r[1:0] != 2'd0) begin
                send_alu(0, alu_op_t'(r[6:4]), rand_word(), rand_word(),
                         reg_num_t'(r[11:8]));
            end
            if (free2 && r[3:2] != 2'd0) begin
                send_alu(1, alu_op_t'(r[9:7]), rand_word(), rand_word(),
                         reg_num_t'(16 + r[15:12]));
            end
            if (free_adv && r[16]) begin
                send_mul(rand_word(), rand_word(), reg_num_t'(32 + r[20:17]),
                         reg_num_t'(48 + (r[24:21] % 15)));
            end
            if (free_br && r[30:29] == 2'd0) begin
                a = rand_word();
                b = r[31] ? a : rand_word();
                send_branch(br_op_t'(r[26:25]), a, b, rand_word(), rand_word());
            end
        end
        drain();
        check_all_regs();

        $display("errors: %0d compare, %0d assertion, %0d timeout",
                 check_errors, assert_errors, timeouts);
        if (check_errors + assert_errors + timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/exec_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_backend import core_pkg::*; #(
    parameter int num_regs = 64
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     alu1_issue,
    input  alu_req_t alu1_req,
    input  logic     alu2_issue,
    input  alu_req_t alu2_req,
    input  logic     adv_issue,
    input  adv_req_t adv_req,
    input  logic     br_issue,
    input  br_req_t  br_req,

    output logic     alu1_stall,
    output logic     alu2_stall,
    output logic     adv_stall,
    output logic     br_stall,

    input  reg_num_t rd_rn,
    output xlen_t    rd_data
);

    // registered results waiting for the single write port
    logic    alu1_valid;
    wb_t     alu1_result;
    logic    alu2_valid;
    wb_t     alu2_result;
    logic    adv_valid;
    adv_wb_t adv_result;
    logic    br_valid;
    xlen_t   br_result;

    // the write chosen by commit for this cycle
    logic    write_en;
    wb_t     write;

    // the two ALUs are identical and share the same stall protocol
    alu_unit i_alu1 (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (alu1_issue),
        .req    (alu1_req),
        .stall  (alu1_stall),
        .valid  (alu1_valid),
        .result (alu1_result)
    );

    alu_unit i_alu2 (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (alu2_issue),
        .req    (alu2_req),
        .stall  (alu2_stall),
        .valid  (alu2_valid),
        .result (alu2_result)
    );

    advint_unit i_advint (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (adv_issue),
        .req    (adv_req),
        .stall  (adv_stall),
        .valid  (adv_valid),
        .result (adv_result)
    );

    branch_unit i_branch (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (br_issue),
        .req    (br_req),
        .stall  (br_stall),
        .valid  (br_valid),
        .result (br_result)
    );

    // stalls go both to the units and out to the issue logic
    commit i_commit (
        .clk         (clk),
        .rst_n       (rst_n),
        .alu1_valid  (alu1_valid),
        .alu1_result (alu1_result),
        .alu2_valid  (alu2_valid),
        .alu2_result (alu2_result),
        .adv_valid   (adv_valid),
        .adv_result  (adv_result),
        .br_valid    (br_valid),
        .br_result   (br_result),
        .alu1_stall  (alu1_stall),
        .alu2_stall  (alu2_stall),
        .adv_stall   (adv_stall),
        .br_stall    (br_stall),
        .write_en    (write_en),
        .write       (write)
    );

    register_file #(
        .num_regs (num_regs)
    ) i_register_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .write_en (write_en),
        .write    (write),
        .rd_rn    (rd_rn),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

/* logic/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file import core_pkg::*; #(
    parameter int num_regs = 64
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     write_en,
    input  wb_t      write,
    input  reg_num_t rd_rn,
    output xlen_t    rd_data
);

    // architectural registers, the last one holds the branch next pc
    xlen_t regs [num_regs];

    // one write per cycle, so there is never a port conflict
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write.rn] <= write.data;
        end
    end

    // observation port, a write shows up here right after its edge
    assign rd_data = regs[rd_rn];

endmodule

`default_nettype wire

/* logic/commit.sv */
`timescale 1ns/1ps
`default_nettype none

module commit import core_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,

    input  logic    alu1_valid,
    input  wb_t     alu1_result,
    input  logic    alu2_valid,
    input  wb_t     alu2_result,
    input  logic    adv_valid,
    input  adv_wb_t adv_result,
    input  logic    br_valid,
    input  xlen_t   br_result,

    output logic    alu1_stall,
    output logic    alu2_stall,
    output logic    adv_stall,
    output logic    br_stall,

    output logic    write_en,
    output wb_t     write
);

    // adv_lo is the normal arbitration state, adv_hi sends the second
    // half of a multiply whose lo half went out in the previous cycle
    typedef enum logic {
        adv_lo = 1'b0,
        adv_hi = 1'b1
    } adv_state_t;

    adv_state_t state;
    adv_state_t state_next;

    always_comb begin
        // every waiting unit is held unless it wins the port below
        alu1_stall = alu1_valid;
        alu2_stall = alu2_valid;
        adv_stall  = adv_valid;
        br_stall   = br_valid;
        write_en   = 1'b0;
        write      = '0;
        state_next = state;

        if (state == adv_hi) begin
            // the multiplier owns the port until its pair is complete
            write_en   = 1'b1;
            write.data = adv_result.hi;
            write.rn   = adv_result.rn2;
            adv_stall  = 1'b0;
            state_next = adv_lo;
        end else if (br_valid) begin
            write_en   = 1'b1;
            write.data = br_result;
            write.rn   = pc_reg;
            br_stall   = 1'b0;
        end else if (alu1_valid) begin
            write_en   = 1'b1;
            write      = alu1_result;
            alu1_stall = 1'b0;
        end else if (alu2_valid) begin
            write_en   = 1'b1;
            write      = alu2_result;
            alu2_stall = 1'b0;
        end else if (adv_valid) begin
            // lo goes out now, adv_stall stays high so hi is kept for later
            write_en   = 1'b1;
            write.data = adv_result.lo;
            write.rn   = adv_result.rn;
            state_next = adv_hi;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= adv_lo;
        end else begin
            state <= state_next;
        end
    end

    // a write must always come from some unit holding a result
    a_write_has_source: assert property (
        @(posedge clk) disable iff (!rst_n)
        write_en |-> (alu1_valid || alu2_valid || adv_valid || br_valid)
    ) else $error("commit: write without a valid result");

    // the multiplier must still hold its result when hi is due
    a_hi_has_result: assert property (
        @(posedge clk) disable iff (!rst_n) (state == adv_hi) |-> adv_valid
    ) else $error("commit: adv_hi state without an advint result");

endmodule

`default_nettype wire

/* logic/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit import core_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    issue,
    input  br_req_t req,
    input  logic    stall,
    output logic    valid,
    output xlen_t   result
);

    // compare outcome and the pc that follows from it
    logic  taken;
    xlen_t next_pc;

    always_comb begin
        case (req.op)
            br_beq:  taken = (req.a == req.b);
            br_bne:  taken = (req.a != req.b);
            br_blt:  taken = ($signed(req.a) < $signed(req.b));
            br_bltu: taken = (req.a < req.b);
            default: taken = 1'b0;
        endcase
    end

    // fall through is the next sequential instruction, four bytes on
    assign next_pc = taken ? req.target : req.pc + xlen_t'(4);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (!stall) begin
            valid <= issue;
        end
    end

    // no destination is stored, commit always sends this to pc_reg
    always_ff @(posedge clk) begin
        if (!stall && issue) begin
            result <= next_pc;
        end
    end

    // branch has top priority so it is only stalled behind a hi write
    a_no_issue_in_stall: assert property (
        @(posedge clk) disable iff (!rst_n) stall |-> !issue
    ) else $error("branch_unit: issue while stalled");

endmodule

`default_nettype wire

/* logic/advint_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module advint_unit import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     issue,
    input  adv_req_t req,
    input  logic     stall,
    output logic     valid,
    output adv_wb_t  result
);

    // full unsigned product, twice the word width
    logic [2*$bits(xlen_t)-1:0] product;

    // the whole multiply is done in the issue cycle
    // a wider core would pipeline this, here one cycle is enough
    assign product = req.a * req.b;

    // valid stays up across both writes because commit keeps stall
    // high during the lo write and drops it for the hi write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (!stall) begin
            valid <= issue;
        end
    end

    // both halves and both destinations are captured together
    always_ff @(posedge clk) begin
        if (!stall && issue) begin
            result.lo  <= product[$bits(xlen_t)-1:0];
            result.hi  <= product[2*$bits(xlen_t)-1:$bits(xlen_t)];
            result.rn  <= req.rn;
            result.rn2 <= req.rn2;
        end
    end

    // a strobe in a stalled cycle would split the lo/hi pair
    a_no_issue_in_stall: assert property (
        @(posedge clk) disable iff (!rst_n) stall |-> !issue
    ) else $error("advint_unit: issue while stalled");

endmodule

`default_nettype wire

/* logic/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     issue,
    input  alu_req_t req,
    input  logic     stall,
    output logic     valid,
    output wb_t      result
);

    // value computed from the incoming request in the issue cycle
    xlen_t alu_value;

    always_comb begin
        case (req.op)
            alu_add: alu_value = req.a + req.b;
            alu_sub: alu_value = req.a - req.b;
            alu_and: alu_value = req.a & req.b;
            alu_or:  alu_value = req.a | req.b;
            alu_xor: alu_value = req.a ^ req.b;
            // shifts only look at the low six bits of b
            alu_sll: alu_value = req.a << req.b[5:0];
            alu_srl: alu_value = req.a >> req.b[5:0];
            // set-less-than is a signed compare, zero extended to a word
            alu_slt: alu_value = {63'd0, $signed(req.a) < $signed(req.b)};
            default: alu_value = '0;
        endcase
    end

    // valid follows issue whenever commit lets the result go
    // while stalled the old result is still waiting for the write port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (!stall) begin
            valid <= issue;
        end
    end

    // the result register only moves when a new operation is accepted
    always_ff @(posedge clk) begin
        if (!stall && issue) begin
            result.data <= alu_value;
            result.rn   <= req.rn;
        end
    end

    // upstream must hold its next operation while commit holds this unit
    // otherwise the pending result would be overwritten before its write
    a_no_issue_in_stall: assert property (
        @(posedge clk) disable iff (!rst_n) stall |-> !issue
    ) else $error("alu_unit: issue while stalled");

endmodule

`default_nettype wire

/* logic/core_pkg.sv */
`default_nettype none

package core_pkg;

    // one architectural data word of the 64-bit core
    typedef logic [63:0] xlen_t;

    // register numbers address the 64-entry register file
    typedef logic [5:0] reg_num_t;

    // the branch unit always writes its next program counter here
    localparam reg_num_t pc_reg = 6'd63;

    // integer ALU operations, encoded in three bits
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_sll = 3'd5,
        alu_srl = 3'd6,
        alu_slt = 3'd7
    } alu_op_t;

    // branch compares; blt is signed and bltu is unsigned
    typedef enum logic [1:0] {
        br_beq  = 2'd0,
        br_bne  = 2'd1,
        br_blt  = 2'd2,
        br_bltu = 2'd3
    } br_op_t;

    // request to one ALU, operands already read by the issue logic
    typedef struct packed {
        alu_op_t  op;
        xlen_t    a;
        xlen_t    b;
        reg_num_t rn;
    } alu_req_t;

    // the multiplier has two destinations, rn for lo and rn2 for hi
    typedef struct packed {
        xlen_t    a;
        xlen_t    b;
        reg_num_t rn;
        reg_num_t rn2;
    } adv_req_t;

    // branch request carries both candidates for the next pc
    typedef struct packed {
        br_op_t op;
        xlen_t  a;
        xlen_t  b;
        xlen_t  pc;
        xlen_t  target;
    } br_req_t;

    // a single register write, as seen by the register file port
    typedef struct packed {
        xlen_t    data;
        reg_num_t rn;
    } wb_t;

    // the registered multiplier result, both halves with their destinations
    typedef struct packed {
        xlen_t    lo;
        xlen_t    hi;
        reg_num_t rn;
        reg_num_t rn2;
    } adv_wb_t;

endpackage

`default_nettype wire
